// ==== design/sd_cmd_pkg.sv ====
// SD command line host shared definitions
// Frame lengths, driver states, request and response records,
// and the rule that maps a command index to its response kind

package sd_cmd_pkg;

	// ========================================
	// Frame geometry
	// ========================================
	localparam int CMD_INDEX_BITS   = 6;
	localparam int CMD_ARG_BITS     = 32;
	localparam int CRC_BITS         = 7;
	localparam int CMD_FRAME_BITS   = 48;
	localparam int CMD_CONTENT_BITS = CMD_FRAME_BITS - CRC_BITS - 1;  // Start..argument
	localparam int SHORT_RESP_BITS  = 48;
	localparam int LONG_RESP_BITS   = 136;
	localparam int LONG_HDR_BITS    = 8;    // Start, transmission, reserved
	localparam int SHORT_CRC_POS    = SHORT_RESP_BITS - CRC_BITS - 1;
	localparam int LONG_CRC_POS     = LONG_RESP_BITS - CRC_BITS - 1;
	localparam int PAYLOAD_BITS     = LONG_CRC_POS - LONG_HDR_BITS;
	localparam int NCR_MAX          = 64;   // Response start bit window
	localparam int CNT_W            = $clog2(LONG_RESP_BITS);
	localparam int NCR_W            = $clog2(NCR_MAX);

	typedef enum logic [1:0] {RESP_NONE, RESP_SHORT, RESP_LONG} resp_kind_e;

	typedef enum logic [2:0] {
		ST_IDLE, ST_SEND_CMD, ST_SEND_CRC, ST_WAIT_RESP, ST_RCV_RESP
	} cmd_state_e;

	typedef enum logic [1:0] {RS_OK, RS_CRC_ERR, RS_TIMEOUT, RS_FRAME_ERR} resp_status_e;

	typedef struct packed {
		logic [CMD_INDEX_BITS-1:0] index;
		logic [CMD_ARG_BITS-1:0]   arg;
	} cmd_req_t;

	typedef struct packed {
		resp_kind_e                kind;
		logic                      timeout;
		logic [CMD_INDEX_BITS-1:0] index;     // Index that was sent
		logic [LONG_RESP_BITS-1:0] bits;      // Right aligned capture
		logic [CRC_BITS-1:0]       crc_calc;
	} resp_frame_t;

	typedef struct packed {
		resp_status_e            status;
		logic [PAYLOAD_BITS-1:0] payload;
	} cmd_result_t;

	// Response kind from command index
	function automatic resp_kind_e resp_kind_of(input logic [CMD_INDEX_BITS-1:0] index);
		resp_kind_e kind;
		case (index)
			6'd0, 6'd4, 6'd15: kind = RESP_NONE;
			6'd2, 6'd9, 6'd10: kind = RESP_LONG;
			default:           kind = RESP_SHORT;
		endcase
		return kind;
	endfunction

endpackage

// ==== design/sd_crc7.sv ====
// Serial CRC7 for the SD command line, polynomial x^7 + x^3 + 1
// Accumulates one bit per clock, then shifts the remainder out
// MSB first while unload is high

`timescale 1ns/1ns

module sd_crc7
(
	input  logic iclk,
	input  logic irst,
	input  logic clear,     // Hold remainder at zero
	input  logic data_bit,
	input  logic unload,    // Shift remainder out, no feedback
	output logic crc_bit
);

	logic [6:0] crc;
	logic       fb;

	assign fb      = data_bit ^ crc[6];
	assign crc_bit = crc[6];

	always_ff @(posedge iclk)
	begin
		if (irst || clear)
		begin
			crc <= '0;
		end
		else if (unload)
		begin
			crc <= {crc[5:0], 1'b0};
		end
		else
		begin
			// Feedback taps at x^3 and x^0
			crc <= {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
		end
	end

endmodule

// ==== design/sd_cmd_driver.sv ====
// SD CMD line driver
// Serializes a 48-bit command with its CRC7, releases the line,
// waits up to NCR_MAX cycles for a response start bit and then
// captures a short or long response for the checker

`timescale 1ns/1ns

module sd_cmd_driver
(
	input  logic                    iclk,
	input  logic                    irst,
	input  logic                    send,
	input  sd_cmd_pkg::cmd_req_t    req,
	inout  wire                     cmd_sd,
	input  logic                    crc_bit,
	output logic                    crc_clear,
	output logic                    crc_unload,
	output logic                    crc_data,
	output logic                    busy,
	output logic                    frame_valid,
	output sd_cmd_pkg::resp_frame_t frame
);

	import sd_cmd_pkg::*;

	cmd_state_e                state;
	logic [CNT_W-1:0]          bit_cnt;
	logic [NCR_W-1:0]          ncr_cnt;
	logic [LONG_RESP_BITS-1:0] sr;          // Command out, response in
	resp_kind_e                kind_q;
	logic [CMD_INDEX_BITS-1:0] index_q;
	logic                      timeout_q;
	logic [CRC_BITS-1:0]       crc_calc_q;

	logic                      accept;
	logic                      line_bit;
	logic                      drive_en;
	logic                      drive_bit;
	logic                      rx_crc_win;
	logic [CNT_W-1:0]          last_pos;
	logic [CNT_W-1:0]          crc_pos;

	assign accept   = (state == ST_IDLE) && send && !busy;
	assign line_bit = cmd_sd;

	assign last_pos = (kind_q == RESP_LONG) ? CNT_W'(LONG_RESP_BITS - 1)
	                                        : CNT_W'(SHORT_RESP_BITS - 1);
	assign crc_pos  = (kind_q == RESP_LONG) ? CNT_W'(LONG_CRC_POS)
	                                        : CNT_W'(SHORT_CRC_POS);

	// Seven received positions right after the content
	assign rx_crc_win = (state == ST_RCV_RESP) && (bit_cnt >= crc_pos) &&
	                    (bit_cnt < crc_pos + CNT_W'(CRC_BITS));

	// ========================================
	// Control FSM
	// ========================================
	always_ff @(posedge iclk)
	begin
		if (irst)
		begin
			state       <= ST_IDLE;
			bit_cnt     <= '0;
			ncr_cnt     <= '0;
			busy        <= 1'b0;
			frame_valid <= 1'b0;
		end
		else
		begin
			frame_valid <= 1'b0;
			if (frame_valid)
				busy <= 1'b0;   // Falls together with done

			case (state)
				ST_IDLE:
				begin
					if (accept)
					begin
						state   <= ST_SEND_CMD;
						busy    <= 1'b1;
						bit_cnt <= '0;
					end
				end
				ST_SEND_CMD:
				begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == CNT_W'(CMD_CONTENT_BITS - 1))
					begin
						state   <= ST_SEND_CRC;
						bit_cnt <= '0;
					end
				end
				ST_SEND_CRC:
				begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == CNT_W'(CRC_BITS))  // End bit on the wire
					begin
						ncr_cnt <= '0;
						if (kind_q == RESP_NONE)
						begin
							state       <= ST_IDLE;
							frame_valid <= 1'b1;
						end
						else
						begin
							state <= ST_WAIT_RESP;
						end
					end
				end
				ST_WAIT_RESP:
				begin
					if (!line_bit)
					begin
						state   <= ST_RCV_RESP;   // Start bit counts as position 0
						bit_cnt <= CNT_W'(1);
					end
					else if (ncr_cnt == NCR_W'(NCR_MAX - 1))
					begin
						state       <= ST_IDLE;
						frame_valid <= 1'b1;
					end
					else
					begin
						ncr_cnt <= ncr_cnt + 1'b1;
					end
				end
				ST_RCV_RESP:
				begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == last_pos)
					begin
						state       <= ST_IDLE;
						frame_valid <= 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// ========================================
	// Shift register and frame fields
	// ========================================
	always_ff @(posedge iclk)
	begin
		case (state)
			ST_IDLE:
			begin
				if (accept)
				begin
					sr        <= LONG_RESP_BITS'({2'b01, req.index, req.arg});
					kind_q    <= resp_kind_of(req.index);
					index_q   <= req.index;
					timeout_q <= 1'b0;
				end
			end
			ST_SEND_CMD:
				sr <= sr << 1;
			ST_SEND_CRC:
			begin
				if (bit_cnt == CNT_W'(CRC_BITS))
					sr <= '0;   // Clean capture area
			end
			ST_WAIT_RESP:
			begin
				if (!line_bit)
					sr <= {sr[LONG_RESP_BITS-2:0], line_bit};
				else if (ncr_cnt == NCR_W'(NCR_MAX - 1))
					timeout_q <= 1'b1;
			end
			ST_RCV_RESP:
			begin
				sr <= {sr[LONG_RESP_BITS-2:0], line_bit};
				if (rx_crc_win)
					crc_calc_q <= {crc_calc_q[CRC_BITS-2:0], crc_bit};
			end
			default: ;
		endcase
	end

	// Line drive and CRC block control
	always_comb
	begin
		drive_en   = (state == ST_SEND_CMD) || (state == ST_SEND_CRC);
		drive_bit  = 1'b1;
		crc_clear  = 1'b0;
		crc_unload = 1'b0;
		crc_data   = line_bit;
		case (state)
			ST_IDLE:      crc_clear = 1'b1;
			ST_SEND_CMD:
			begin
				drive_bit = sr[CMD_CONTENT_BITS-1];
				crc_data  = sr[CMD_CONTENT_BITS-1];
			end
			ST_SEND_CRC:
			begin
				if (bit_cnt < CNT_W'(CRC_BITS))
				begin
					drive_bit  = crc_bit;
					crc_unload = 1'b1;
				end
			end
			ST_WAIT_RESP: crc_clear = 1'b1;   // Start bit is zero anyway
			ST_RCV_RESP:
			begin
				// Long response CRC skips the header byte
				crc_clear  = (kind_q == RESP_LONG) && (bit_cnt < CNT_W'(LONG_HDR_BITS));
				crc_unload = rx_crc_win;
			end
			default: ;
		endcase
	end

	assign cmd_sd = drive_en ? drive_bit : 1'bz;

	assign frame = '{
		kind:     kind_q,
		timeout:  timeout_q,
		index:    index_q,
		bits:     sr,
		crc_calc: crc_calc_q
	};

endmodule

// ==== design/sd_resp_check.sv ====
// Response checker
// Judges a captured response frame and extracts the card status
// or the long response content, one result per frame strobe

`timescale 1ns/1ns

module sd_resp_check
(
	input  logic                    iclk,
	input  logic                    irst,
	input  logic                    frame_valid,
	input  sd_cmd_pkg::resp_frame_t frame,
	output logic                    done,
	output sd_cmd_pkg::cmd_result_t result
);

	import sd_cmd_pkg::*;

	cmd_result_t                judged;
	logic [SHORT_RESP_BITS-1:0] s_bits;
	logic [LONG_RESP_BITS-1:0]  l_bits;

	always_comb
	begin
		s_bits         = frame.bits[SHORT_RESP_BITS-1:0];
		l_bits         = frame.bits;
		judged.status  = RS_OK;
		judged.payload = '0;
		if (frame.timeout)
		begin
			judged.status = RS_TIMEOUT;
		end
		else
		begin
			case (frame.kind)
				RESP_SHORT:
				begin
					// Transmission bit, echoed index, end bit
					if (s_bits[46] || (s_bits[45:40] != frame.index) || !s_bits[0])
						judged.status = RS_FRAME_ERR;
					else if (s_bits[7:1] != frame.crc_calc)
						judged.status = RS_CRC_ERR;
					else
						judged.payload = PAYLOAD_BITS'(s_bits[39:8]);
				end
				RESP_LONG:
				begin
					// Reserved field must read all ones
					if (l_bits[134] || (l_bits[133:128] != '1) || !l_bits[0])
						judged.status = RS_FRAME_ERR;
					else if (l_bits[7:1] != frame.crc_calc)
						judged.status = RS_CRC_ERR;
					else
						judged.payload = l_bits[127:8];
				end
				default: ;   // No response, nothing to judge
			endcase
		end
	end

	always_ff @(posedge iclk)
	begin
		if (irst)
			done <= 1'b0;
		else
			done <= frame_valid;
	end

	// Held until the next frame
	always_ff @(posedge iclk)
	begin
		if (frame_valid)
			result <= judged;
	end

endmodule

// ==== design/sd_cmd_host.sv ====
// SD command line host top level
// Joins the line driver, the CRC7 generator and the response
// checker and exposes the bidirectional CMD wire

`timescale 1ns/1ns

module sd_cmd_host
(
	input  logic                    iclk,
	input  logic                    irst,
	input  logic                    send,     // Ignored while busy
	input  sd_cmd_pkg::cmd_req_t    req,
	inout  wire                     cmd_sd,
	output logic                    busy,
	output logic                    done,
	output sd_cmd_pkg::cmd_result_t result
);

	import sd_cmd_pkg::*;

	logic        crc_clear;
	logic        crc_unload;
	logic        crc_data;
	logic        crc_bit;
	logic        frame_valid;
	resp_frame_t frame;

	sd_cmd_driver driver_i
	(
		.iclk        (iclk),
		.irst        (irst),
		.send        (send),
		.req         (req),
		.cmd_sd      (cmd_sd),
		.crc_bit     (crc_bit),
		.crc_clear   (crc_clear),
		.crc_unload  (crc_unload),
		.crc_data    (crc_data),
		.busy        (busy),
		.frame_valid (frame_valid),
		.frame       (frame)
	);

	sd_crc7 crc_i
	(
		.iclk     (iclk),
		.irst     (irst),
		.clear    (crc_clear),
		.data_bit (crc_data),
		.unload   (crc_unload),
		.crc_bit  (crc_bit)
	);

	sd_resp_check check_i
	(
		.iclk        (iclk),
		.irst        (irst),
		.frame_valid (frame_valid),
		.frame       (frame),
		.done        (done),
		.result      (result)
	);

endmodule

// ==== test/sd_card_model.sv ====
// Behavioral SD card on the CMD line
// Captures each 48-bit command, checks its CRC7 and answers
// after a set delay with a short or long response

`timescale 1ns/1ns

module sd_card_model
(
	input  logic                   iclk,
	input  logic                   irst,
	inout  wire                    cmd_sd,
	input  sd_cmd_pkg::resp_kind_e kind,
	input  logic                   reply_en,
	input  logic [6:0]             delay,      // Cycles after the command end bit
	input  logic [119:0]           payload,
	input  logic [2:0]             faults,     // CRC, echoed index, end bit
	output logic [47:0]            cmd_frame,
	output logic                   cmd_crc_ok,
	output int                     cmd_count
);

	import sd_cmd_pkg::*;

	logic [47:0]  rx;
	logic [47:0]  rx_next;
	int           rx_cnt;
	logic [135:0] tx;           // Response, right aligned
	int           tx_len;
	int           tx_left;
	int           wait_cnt;
	logic         drive;
	logic         out_bit;

	assign cmd_sd  = drive ? out_bit : 1'bz;
	assign rx_next = {rx[46:0], cmd_sd};

	// Reference CRC7 over the low n bits, MSB first
	function automatic logic [6:0] crc7_of(input logic [135:0] v, input int n);
		logic [6:0] c;
		logic       fb;
		c = '0;
		for (int i = n - 1; i >= 0; i--)
		begin
			fb = v[i] ^ c[6];
			c  = {c[5:0], 1'b0} ^ {3'b000, fb, 2'b00, fb};
		end
		return c;
	endfunction

	function automatic logic [135:0] build_resp(input logic [5:0] index);
		logic [39:0] body;
		logic [6:0]  crc;
		if (kind == RESP_LONG)
		begin
			crc = crc7_of(136'(payload), 120) ^ {6'd0, faults[2]};
			return {8'h3f, payload, crc, !faults[0]};
		end
		body = {2'b00, index ^ {5'd0, faults[1]}, payload[31:0]};
		crc  = crc7_of(136'(body), 40) ^ {6'd0, faults[2]};
		return {88'd0, body, crc, !faults[0]};
	endfunction

	// ========================================
	// Line activity, all on the falling edge
	// ========================================
	always @(negedge iclk)
	begin
		if (irst)
		begin
			rx_cnt    <= 0;
			tx_left   <= 0;
			wait_cnt  <= 0;
			drive     <= 1'b0;
			cmd_count <= 0;
		end
		else if (tx_left > 0)
		begin
			out_bit <= tx[tx_left-1];
			tx_left <= tx_left - 1;
		end
		else if (wait_cnt > 0)
		begin
			wait_cnt <= wait_cnt - 1;
			if (wait_cnt == 1)
			begin
				drive   <= 1'b1;              // Response start bit
				out_bit <= tx[tx_len-1];
				tx_left <= tx_len - 1;
			end
		end
		else if (drive)
			drive <= 1'b0;                    // Release after the end bit
		else if (rx_cnt > 0 || cmd_sd === 1'b0)
		begin
			rx     <= rx_next;
			rx_cnt <= rx_cnt + 1;
			if (rx_cnt == CMD_FRAME_BITS - 1)
			begin
				rx_cnt     <= 0;
				cmd_frame  <= rx_next;
				cmd_crc_ok <= crc7_of(136'(rx_next[47:8]), 40) == rx_next[7:1];
				cmd_count  <= cmd_count + 1;
				if (reply_en && kind != RESP_NONE)
				begin
					tx       <= build_resp(rx_next[45:40]);
					tx_len   <= (kind == RESP_LONG) ? LONG_RESP_BITS : SHORT_RESP_BITS;
					wait_cnt <= int'(delay) + 1;
				end
			end
		end
	end

endmodule

// ==== test/sd_cmd_props.sv ====
// CMD line driver properties
// Line ownership, frame strobe width and the busy level

`timescale 1ns/1ns

module sd_cmd_props
(
	input logic iclk,
	input logic irst,
	input logic accept,
	input logic busy,
	input logic frame_valid,
	input logic drive_en
);

	import sd_cmd_pkg::*;

	// Line owned for the command frame only, released right after it
	assert property (@(posedge iclk) disable iff (irst)
		accept |=> drive_en ##(CMD_FRAME_BITS) !drive_en)
		else $error("CMD line not released after the command frame");

	assert property (@(posedge iclk) disable iff (irst) frame_valid |=> !frame_valid)
		else $error("frame_valid longer than one cycle");

	assert property (@(posedge iclk) disable iff (irst)
		(accept || (busy && !frame_valid)) |=> busy)
		else $error("busy dropped before frame_valid");

	assert property (@(posedge iclk) irst |=> !busy)
		else $error("busy not cleared by reset");

endmodule

bind sd_cmd_driver sd_cmd_props props_i
(
	.iclk        (iclk),
	.irst        (irst),
	.accept      (accept),
	.busy        (busy),
	.frame_valid (frame_valid),
	.drive_en    (drive_en)
);

// ==== test/tb_sd_cmd.sv ====
// Testbench for the SD command line host
// Sends each table row to the DUT, lets the card model answer
// and compares status, payload, framing and timing

`timescale 1ns/1ns

module tb_sd_cmd;

	import sd_cmd_pkg::*;

	localparam int NROWS        = 11;
	localparam int CLK_NS       = 100;
	localparam int LATENCY_NONE = 50;
	localparam int WATCHDOG_NS  =
		NROWS * (CMD_FRAME_BITS + LONG_RESP_BITS + NCR_MAX + 20) * CLK_NS;

	typedef struct packed {
		cmd_req_t     req;
		resp_kind_e   kind;
		logic [6:0]   delay;
		logic         reply;
		logic [7:0]   pseed;
		logic [2:0]   faults;   // CRC, echoed index, end bit
		logic         resend;   // Extra strobe while busy
		resp_status_e exp;
	} row_t;

	// ========================================
	// Stimulus and expected status
	// ========================================
	localparam row_t ROWS [NROWS] = '{
		'{'{6'd0,  32'h0000_0000}, RESP_NONE,  7'd0,  1'b0, 8'h00, 3'b000, 1'b0, RS_OK},
		'{'{6'd15, 32'h0001_0000}, RESP_NONE,  7'd0,  1'b0, 8'h11, 3'b000, 1'b0, RS_OK},
		'{'{6'd13, 32'h0001_0000}, RESP_SHORT, 7'd2,  1'b1, 8'h22, 3'b000, 1'b0, RS_OK},
		'{'{6'd17, 32'h0000_0200}, RESP_SHORT, 7'd60, 1'b1, 8'h33, 3'b000, 1'b0, RS_OK},
		'{'{6'd2,  32'h0000_0000}, RESP_LONG,  7'd2,  1'b1, 8'h44, 3'b000, 1'b0, RS_OK},
		'{'{6'd9,  32'h1234_0000}, RESP_LONG,  7'd60, 1'b1, 8'h55, 3'b000, 1'b0, RS_OK},
		'{'{6'd16, 32'h0000_0200}, RESP_SHORT, 7'd5,  1'b1, 8'h66, 3'b100, 1'b0, RS_CRC_ERR},
		'{'{6'd7,  32'h1234_0000}, RESP_SHORT, 7'd3,  1'b1, 8'h77, 3'b010, 1'b0, RS_FRAME_ERR},
		'{'{6'd55, 32'h1234_0000}, RESP_SHORT, 7'd3,  1'b1, 8'h88, 3'b001, 1'b0, RS_FRAME_ERR},
		'{'{6'd10, 32'h5678_0000}, RESP_LONG,  7'd8,  1'b1, 8'h99, 3'b100, 1'b0, RS_CRC_ERR},
		'{'{6'd8,  32'h0000_01aa}, RESP_SHORT, 7'd0,  1'b0, 8'haa, 3'b000, 1'b1, RS_TIMEOUT}
	};

	logic                    iclk;
	logic                    irst;
	logic                    send;
	cmd_req_t                req;
	wire                     cmd_sd;
	logic                    busy;
	logic                    done;
	cmd_result_t             result;
	row_t                    cur;
	logic [PAYLOAD_BITS-1:0] pay;
	logic [47:0]             cmd_frame;
	logic                    cmd_crc_ok;
	int                      cmd_count;
	int                      done_count = 0;
	int                      seed = 68537;

	pullup (cmd_sd);

	sd_cmd_host dut_i
	(
		.iclk   (iclk),
		.irst   (irst),
		.send   (send),
		.req    (req),
		.cmd_sd (cmd_sd),
		.busy   (busy),
		.done   (done),
		.result (result)
	);

	sd_card_model card_i
	(
		.iclk       (iclk),
		.irst       (irst),
		.cmd_sd     (cmd_sd),
		.kind       (cur.kind),
		.reply_en   (cur.reply),
		.delay      (cur.delay),
		.payload    (pay),
		.faults     (cur.faults),
		.cmd_frame  (cmd_frame),
		.cmd_crc_ok (cmd_crc_ok),
		.cmd_count  (cmd_count)
	);

	initial
	begin
		iclk = 1'b0;
		forever #(CLK_NS / 2) iclk = ~iclk;
	end

	always @(posedge iclk)
	begin
		if (!irst && done)
			done_count <= done_count + 1;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the DUT did not finish all rows in time");
		$display("Test failures found");
		$fatal(1, "Watchdog expired");
	end

	task automatic stop_run();
		$display("Test failures found");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic check_status(input string name, input resp_status_e got,
		input resp_status_e exp);
		if (got !== exp)
		begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_payload(input string name, input logic [PAYLOAD_BITS-1:0] got,
		input logic [PAYLOAD_BITS-1:0] exp);
		if (got !== exp)
		begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_req(input string name, input cmd_req_t got, input cmd_req_t exp);
		if (got !== exp)
		begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	// ========================================
	// Row loop
	// ========================================
	initial
	begin
		int                      lat;
		int                      dc0;
		int                      cc0;
		logic [PAYLOAD_BITS-1:0] exp_pay;
		irst = 1'b1;
		send = 1'b0;
		req  = '0;
		cur  = ROWS[0];
		pay  = '0;
		repeat (8) @(negedge iclk);
		irst = 1'b0;
		repeat (2) @(negedge iclk);
		for (int r = 0; r < NROWS; r++)
		begin
			cur = ROWS[r];
			for (int w = 0; w < 4; w++)
				pay = {pay[PAYLOAD_BITS-33:0], 32'($random(seed))};
			pay[7:0] = pay[7:0] ^ cur.pseed;
			cc0      = cmd_count;
			dc0      = done_count;
			req      = cur.req;
			send     = 1'b1;
			@(negedge iclk);
			check_level("busy", busy, 1'b1);
			check_level("cmd start bit", cmd_sd, 1'b0);   // First cycle after the send
			lat = 1;
			while (done !== 1'b1)
			begin
				send = cur.resend && (lat == 5);   // Ignored, DUT is busy
				@(negedge iclk);
				lat++;
			end
			if (cur.kind == RESP_NONE && lat != LATENCY_NONE)
			begin
				$display("Done came %0d cycles after the send instead of %0d", lat,
					LATENCY_NONE);
				stop_run();
			end
			exp_pay = '0;
			if (cur.exp == RS_OK && cur.kind == RESP_LONG)
				exp_pay = pay;
			else if (cur.exp == RS_OK && cur.kind == RESP_SHORT)
				exp_pay = PAYLOAD_BITS'(pay[31:0]);   // Card status only
			check_status("result.status", result.status, cur.exp);
			check_payload("result.payload", result.payload, exp_pay);
			check_level("busy", busy, 1'b0);
			repeat (cur.resend ? 60 : 2) @(negedge iclk);
			if (cmd_count != cc0 + 1 || done_count != dc0 + 1)
			begin
				$display("Row %0d produced %0d commands and %0d done pulses instead of one",
					r, cmd_count - cc0, done_count - dc0);
				stop_run();
			end
			// Command as the card saw it
			check_level("cmd transmission bit", cmd_frame[46], 1'b1);
			check_req("cmd index and argument", cmd_frame[45:8], cur.req);
			check_level("cmd CRC7 match", cmd_crc_ok, 1'b1);
			check_level("cmd end bit", cmd_frame[0], 1'b1);
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== sd_cmd.f ====
design/sd_cmd_pkg.sv
design/sd_crc7.sv
design/sd_cmd_driver.sv
design/sd_resp_check.sv
design/sd_cmd_host.sv
test/sd_card_model.sv
test/sd_cmd_props.sv
test/tb_sd_cmd.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_sd_cmd
FILELIST  := sd_cmd.f
OBJ_DIR   := obj_dir
PASS_MSG  := All tests passed!

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
